//--- files.f
design/cabs_pkg.sv
design/cabs_sample_if.sv
design/cabs_result_if.sv
design/cabs_beat_splitter.sv
design/cabs_magnitude.sv
design/cabs_beat_collector.sv
design/axis_cabs_serial.sv
test/cabs_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cabs_tb -f files.f

status=0
./obj_dir/Vcabs_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "All tests passed" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

//--- test/cabs_golden.txt
// per beat: one line of 4 input words, im in the upper 16 bits, re in the lower 16 bits
// then one line of the 4 expected magnitudes floor(sqrt(re^2 + im^2)), same channel order
00000000 00000001 00010000 00040003
0000 0001 0001 0005
0004FFFD FFFC0003 FFFCFFFD 00000064
0005 0005 0005 0064
FF9C0000 00008000 80000000 80008000
0064 8000 8000 B504
7FFF7FFF 00007FFF 7FFF8000 00010001
B503 7FFF B504 0001
000C0005 000F0008 00180007 00150014
000D 0011 0019 001D
FFF4FFFB 000FFFF8 FFE80007 0015FFEC
000D 0011 0019 001D
00020002 00030002 000A000A 00020001
0002 0003 000E 0002
0190012C 0320FDA8 F9C004B0 F060F448
01F4 03E8 07D0 1388
000000FF 01000000 FFFFFFFF 0000FFFF
00FF 0100 0001 0001
00280009 0023000C 002D001C 003C000B
0029 0025 0035 003D
003F0010 00380021 00370030 0054000D
0041 0041 0049 0055
03E803E8 03E8FC18 00640064 FF9CFF9C
0586 0586 008D 008D
3A984E20 C180D120 1B585DC0 2EE0DCD8
61A8 4E20 61A8 3A98
3E807530 E0C0C568 4E205208 DA80E3E0
84D0 4268 7148 2EE0
00003039 CFC70000 0000FB2E 10E10000
3039 3039 04D2 10E1
00080006 0008FFFA FFB0003C 00010002
000A 000A 0064 0002

//--- test/cabs_tb.sv
// testbench for axis_cabs_serial: replays the golden beats under random back-pressure and checks all outputs
`timescale 1ns/1ps

module cabs_tb;

  import cabs_pkg::*;

  localparam int NUM_CHANNELS = 4;
  localparam int NUM_BEATS = 16;
  localparam int CLK_HALF = 2;
  localparam int RESET_CYCLES = 4;
  localparam int GOLDEN_WORDS = 2 * NUM_BEATS * NUM_CHANNELS;
  // bound on the whole run in ns
  localparam int WATCHDOG_NS = NUM_BEATS * (MAG_LATENCY + 4 * NUM_CHANNELS + 16) * 4 + 200;

  logic                             clk;
  logic                             arst_n;
  logic                             s_tvalid;
  logic                             s_tready;
  logic [NUM_CHANNELS*SAMPLE_W-1:0] s_tdata;
  logic                             m_tvalid;
  logic                             m_tready;
  logic [NUM_CHANNELS*SAMPLE_W-1:0] m_tdata;
  logic [NUM_CHANNELS*MAG_W-1:0]    m_tmag;

  logic [SAMPLE_W-1:0] golden_mem [GOLDEN_WORDS];
  cabs_sample_u        in_words [NUM_BEATS][NUM_CHANNELS];
  mag_t                exp_mags [NUM_BEATS][NUM_CHANNELS];

  // beats accepted by the DUT, oldest first
  int                               sent_q [$];
  int                               tx_beat;
  int                               rx_count;
  logic [15:0]                      lfsr_q;
  logic                             hold_check;
  logic [NUM_CHANNELS*SAMPLE_W-1:0] held_data;
  logic [NUM_CHANNELS*MAG_W-1:0]    held_mag;

  axis_cabs_serial #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) axis_cabs_serial_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tmag   (m_tmag)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic take_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_sample(input string name, input int beat, input cabs_sample_u got,
                              input cabs_sample_u exp);
    if (got.raw !== exp.raw) begin
      $display("ERR %s beat %0d: got 0x%08h expected 0x%08h", name, beat, got.raw, exp.raw);
      abort_run();
    end
  endtask

  task automatic check_mag(input string name, input int beat, input mag_t got, input mag_t exp);
    if (got !== exp) begin
      $display("ERR %s beat %0d: got 0x%04h expected 0x%04h", name, beat, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_beat(input int beat);
    cabs_sample_u got_s;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      got_s = m_tdata[c*SAMPLE_W +: SAMPLE_W];
      check_sample($sformatf("m_tdata[%0d]", c), beat, got_s, in_words[beat][c]);
      check_mag($sformatf("m_tmag[%0d]", c), beat, m_tmag[c*MAG_W +: MAG_W], exp_mags[beat][c]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog, monitors
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_failure($sformatf("timeout: the run did not finish within %0d ns", WATCHDOG_NS));
  end

  // output transfers, in order
  always @(posedge clk) begin : output_monitor
    int beat;
    if (arst_n) begin
      if (m_tvalid && m_tready) begin
        if (sent_q.size() == 0) begin
          report_failure("output beat arrived with no matching input beat");
        end
        beat = sent_q.pop_front();
        compare_beat(beat);
        rx_count++;
      end
      hold_check = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_mag = m_tmag;
    end
  end

  // an unaccepted beat must not move
  always @(negedge clk) begin : hold_monitor
    if (arst_n) begin
      if (m_tvalid && tx_beat == 0) begin
        report_failure("m_tvalid went high before any input beat was accepted");
      end
      if (hold_check) begin
        if (!m_tvalid) begin
          report_failure("m_tvalid dropped while the output beat waited for m_tready");
        end
        if (m_tdata !== held_data) begin
          $display("ERR m_tdata changed while held: got 0x%h expected 0x%h", m_tdata, held_data);
          abort_run();
        end
        if (m_tmag !== held_mag) begin
          $display("ERR m_tmag changed while held: got 0x%h expected 0x%h", m_tmag, held_mag);
          abort_run();
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int   r;
    int   gap;
    logic xfer;
    arst_n = 1'b0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    m_tready = 1'b0;
    tx_beat = 0;
    rx_count = 0;
    hold_check = 1'b0;
    lfsr_q = 16'd43898;
    gap = 0;
    xfer = 1'b0;

    $readmemh("test/cabs_golden.txt", golden_mem);
    for (int b = 0; b < NUM_BEATS; b++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        in_words[b][c] = golden_mem[2*NUM_CHANNELS*b + c];
        exp_mags[b][c] = golden_mem[2*NUM_CHANNELS*b + NUM_CHANNELS + c][MAG_W-1:0];
      end
    end

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (s_tready || m_tvalid) begin
        report_failure("s_tready or m_tvalid was high during reset");
      end
    end
    arst_n = 1'b1;
    @(negedge clk);
    if (s_tready || m_tvalid) begin
      report_failure("s_tready or m_tvalid was high right after reset");
    end

    while (rx_count < NUM_BEATS) begin
      // roughly one cycle in four without m_tready
      take_bits(2, r);
      m_tready = (r != 0);
      if (xfer) begin
        s_tvalid = 1'b0;
        xfer = 1'b0;
      end
      if (!s_tvalid && tx_beat < NUM_BEATS) begin
        if (gap == 0) begin
          s_tvalid = 1'b1;
          for (int c = 0; c < NUM_CHANNELS; c++) begin
            s_tdata[c*SAMPLE_W +: SAMPLE_W] = in_words[tx_beat][c].raw;
          end
        end else begin
          gap--;
        end
      end
      @(posedge clk);
      if (s_tvalid && s_tready) begin
        sent_q.push_back(tx_beat);
        tx_beat++;
        xfer = 1'b1;
        // half the beats follow back to back
        take_bits(2, r);
        gap = (r < 2) ? 0 : r - 1;
      end
      @(negedge clk);
    end

    // drain, anything more would be an extra beat
    s_tvalid = 1'b0;
    m_tready = 1'b1;
    repeat (2 * MAG_LATENCY) @(negedge clk);

    if (rx_count == NUM_BEATS && tx_beat == NUM_BEATS && sent_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      report_failure("number of output beats does not match the number of input beats");
    end
  end

endmodule

//--- design/axis_cabs_serial.sv
// top level: complex magnitude of every channel in a stream beat, one shared pipeline
`timescale 1ns/1ps

module axis_cabs_serial #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  // input stream
  input  logic                                    s_tvalid,
  output logic                                    s_tready,
  input  logic [NUM_CHANNELS*cabs_pkg::SAMPLE_W-1:0] s_tdata,
  // output stream, beat and its magnitudes side by side
  output logic                                    m_tvalid,
  input  logic                                    m_tready,
  output logic [NUM_CHANNELS*cabs_pkg::SAMPLE_W-1:0] m_tdata,
  output logic [NUM_CHANNELS*cabs_pkg::MAG_W-1:0]    m_tmag
);

  // freezes the whole pipeline
  logic stall;

  cabs_sample_if #(.NUM_CHANNELS(NUM_CHANNELS)) smp_if ();
  cabs_result_if #(.NUM_CHANNELS(NUM_CHANNELS)) res_if ();

  cabs_beat_splitter #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) splitter_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .stall    (stall),
    .smp      (smp_if.src)
  );

  cabs_magnitude magnitude_i (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .smp    (smp_if.snk),
    .res    (res_if.src)
  );

  cabs_beat_collector #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) collector_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .res      (res_if.snk),
    .stall    (stall),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tmag   (m_tmag)
  );

endmodule

//--- design/cabs_beat_collector.sv
// output side: gathers per-channel results into a beat and drives the registered output stream
`timescale 1ns/1ps

module cabs_beat_collector #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  cabs_result_if.snk                              res,
  output logic                                    stall,
  output logic                                    m_tvalid,
  input  logic                                    m_tready,
  output logic [NUM_CHANNELS*cabs_pkg::SAMPLE_W-1:0] m_tdata,
  output logic [NUM_CHANNELS*cabs_pkg::MAG_W-1:0]    m_tmag
);

  import cabs_pkg::*;

  // per-channel storage, indexed by the result channel
  cabs_sample_u smp_st [NUM_CHANNELS];
  mag_t         mag_st [NUM_CHANNELS];

  logic [NUM_CHANNELS*SAMPLE_W-1:0] beat_data;
  logic [NUM_CHANNELS*MAG_W-1:0]    beat_mag;
  logic                             complete_q;
  logic                             load;

  always_ff @(posedge clk) begin
    if (res.valid) begin
      smp_st[res.chan] <= res.sample;
      mag_st[res.chan] <= res.mag;
    end
  end

  for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_pack
    assign beat_data[n*SAMPLE_W +: SAMPLE_W] = smp_st[n].raw;
    assign beat_mag[n*MAG_W +: MAG_W]        = mag_st[n];
  end

  ////////////////////////////////////////////////////////////////////////////
  // beat completion and stall
  ////////////////////////////////////////////////////////////////////////////

  // output register free, or being emptied this cycle
  assign load  = complete_q & (~m_tvalid | m_tready);
  // finished beat has nowhere to go
  assign stall = complete_q & m_tvalid & ~m_tready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      complete_q <= 1'b0;
    end else begin
      complete_q <= (res.valid & res.done) | (complete_q & ~load);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_tvalid <= 1'b0;
    end else if (load) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_tdata <= beat_data;
      m_tmag  <= beat_mag;
    end
  end

  // the pipeline holds its results back while the beat waits
  a_no_result_in_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(res.valid && stall)
  );

  a_out_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tmag))
  );

endmodule

//--- design/cabs_magnitude.sv
// processing part: pipelined floor(sqrt(re^2 + im^2)) with the sample tag carried alongside
`timescale 1ns/1ps

module cabs_magnitude (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       stall,
  cabs_sample_if.snk smp,
  cabs_result_if.src res
);

  import cabs_pkg::*;

  localparam int CHAN_W = $bits(smp.chan);
  localparam int POW_W = 2 * COMP_W;
  // remainder of the root recurrence, two bits per step plus a spare
  localparam int REM_W = MAG_W + 3;
  localparam int LAST = MAG_LATENCY - 1;

  // tag pipeline
  logic              vld_q  [0:LAST];
  cabs_sample_u      smp_q  [0:LAST];
  logic [CHAN_W-1:0] chan_q [0:LAST];
  logic              done_q [0:LAST];

  // arithmetic pipeline
  logic [POW_W-1:0]  re_sq_q;
  logic [POW_W-1:0]  im_sq_q;
  logic [POW_W-1:0]  pw_q    [0:MAG_W];
  logic [REM_W-1:0]  rem_q   [1:MAG_W];
  mag_t              root_q  [1:MAG_W];
  logic [REM_W-1:0]  rem_nx  [0:MAG_W-1];
  mag_t              root_nx [0:MAG_W-1];

  ////////////////////////////////////////////////////////////////////////////
  // restoring square root, one result bit per stage
  ////////////////////////////////////////////////////////////////////////////

  for (genvar s = 0; s < MAG_W; s++) begin : g_root
    logic [REM_W-1:0] rem_in;
    mag_t             root_in;
    logic [REM_W-1:0] rem_shf;
    logic [REM_W-1:0] trial;
    logic             take;

    if (s == 0) begin : g_first
      assign rem_in  = '0;
      assign root_in = '0;
    end else begin : g_next
      assign rem_in  = rem_q[s];
      assign root_in = root_q[s];
    end

    // bring down the next bit pair of the power, msb first
    assign rem_shf = {rem_in[REM_W-3:0], pw_q[s][POW_W-1-2*s -: 2]};
    assign trial   = {1'b0, root_in, 2'b01};
    assign take    = (rem_shf >= trial);

    assign rem_nx[s]  = take ? rem_shf - trial : rem_shf;
    assign root_nx[s] = {root_in[MAG_W-2:0], take};
  end

  // valid bits, everything frozen while stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < MAG_LATENCY; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else if (!stall) begin
      vld_q[0] <= smp.valid;
      for (int i = 1; i < MAG_LATENCY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      smp_q[0]  <= smp.sample;
      chan_q[0] <= smp.chan;
      done_q[0] <= smp.done;
      for (int i = 1; i < MAG_LATENCY; i++) begin
        smp_q[i]  <= smp_q[i-1];
        chan_q[i] <= chan_q[i-1];
        done_q[i] <= done_q[i-1];
      end
      // signed squares, never above 2^30
      re_sq_q <= smp.sample.iq.re * smp.sample.iq.re;
      im_sq_q <= smp.sample.iq.im * smp.sample.iq.im;
      pw_q[0] <= re_sq_q + im_sq_q;
      for (int s = 0; s < MAG_W; s++) begin
        pw_q[s+1]   <= pw_q[s];
        rem_q[s+1]  <= rem_nx[s];
        root_q[s+1] <= root_nx[s];
      end
    end
  end

  // result is withheld while the collector is full
  assign res.valid  = vld_q[LAST] & ~stall;
  assign res.sample = smp_q[LAST];
  assign res.chan   = chan_q[LAST];
  assign res.done   = done_q[LAST];
  assign res.mag    = root_q[MAG_W];

  // root squared never exceeds the power, and the remainder closes the gap
  a_mag_floor: assert property (
    @(posedge clk) disable iff (!arst_n)
    vld_q[LAST] |->
      (POW_W'(root_q[MAG_W]) * POW_W'(root_q[MAG_W]) <= pw_q[MAG_W]) &&
      (POW_W'(rem_q[MAG_W]) ==
       pw_q[MAG_W] - POW_W'(root_q[MAG_W]) * POW_W'(root_q[MAG_W]))
  );

endmodule

//--- design/cabs_beat_splitter.sv
// input side of axis_cabs_serial that walks each stream beat into the shared pipeline per channel
`timescale 1ns/1ps

module cabs_beat_splitter #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    s_tvalid,
  output logic                                    s_tready,
  input  logic [NUM_CHANNELS*cabs_pkg::SAMPLE_W-1:0] s_tdata,
  input  logic                                    stall,
  cabs_sample_if.src                              smp
);

  import cabs_pkg::*;

  localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
  localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHANNELS - 1);

  cabs_sample_u      words [NUM_CHANNELS];
  logic [CHAN_W-1:0] chan_q;
  logic              at_last;
  logic              advance;

  // unpack the beat into channel words
  for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_unpack
    assign words[n] = s_tdata[n*SAMPLE_W +: SAMPLE_W];
  end

  assign at_last = (chan_q == LAST_CHAN);
  assign advance = s_tvalid & ~stall;

  // beat is taken together with its last channel
  assign s_tready = at_last & ~stall;

  ////////////////////////////////////////////////////////////////////////////
  // channel counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chan_q <= '0;
    end else if (s_tvalid && s_tready) begin
      chan_q <= '0;
    end else if (advance) begin
      chan_q <= chan_q + 1'b1;
    end
  end

  // serialized sample towards the pipeline
  assign smp.valid  = advance;
  assign smp.sample = words[chan_q];
  assign smp.chan   = chan_q;
  assign smp.done   = at_last & ~stall;

  // the beat is read over several cycles and must hold until taken
  a_in_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (s_tvalid && !s_tready) |=> (s_tvalid && $stable(s_tdata))
  );

endmodule

//--- design/cabs_result_if.sv
// carries one sample with its magnitude from the magnitude pipeline to the beat collector
`timescale 1ns/1ps

interface cabs_result_if #(
  parameter int NUM_CHANNELS = 4
);

  import cabs_pkg::*;

  localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  logic              valid;
  // original word, passed through untouched
  cabs_sample_u      sample;
  logic [CHAN_W-1:0] chan;
  logic              done;
  mag_t              mag;

  modport src (output valid, sample, chan, done, mag);
  modport snk (input valid, sample, chan, done, mag);

endinterface

//--- design/cabs_sample_if.sv
// carries one serialized sample per cycle from the beat splitter into the magnitude pipeline
`timescale 1ns/1ps

interface cabs_sample_if #(
  parameter int NUM_CHANNELS = 4
);

  import cabs_pkg::*;

  // a single channel still needs one index bit
  localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  logic              valid;
  cabs_sample_u      sample;
  logic [CHAN_W-1:0] chan;
  // last channel of the beat
  logic              done;

  modport src (output valid, sample, chan, done);
  modport snk (input valid, sample, chan, done);

endinterface

//--- design/cabs_pkg.sv
// shared widths, latency and sample types for the complex magnitude stream subsystem
package cabs_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // one complex sample, im in the upper half, re in the lower half
  localparam int SAMPLE_W = 32;
  localparam int COMP_W = 16;

  // floor(sqrt(re^2 + im^2)) peaks at 46340, fits unsigned 16 bits
  localparam int MAG_W = 16;

  // square, sum, then one stage per root bit
  localparam int MAG_LATENCY = 2 + MAG_W;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // same word, seen as a bus word or as its two signed components
  typedef union packed {
    logic [SAMPLE_W-1:0] raw;
    struct packed {
      logic signed [COMP_W-1:0] im;
      logic signed [COMP_W-1:0] re;
    } iq;
  } cabs_sample_u;

  // unsigned magnitude result
  typedef logic [MAG_W-1:0] mag_t;

endpackage
